// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_jtkcpu_exec
FILELIST = jtkcpu_exec.f

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== exec_cases.txt ====
# wait op wide dst src_a src_b use_imm imm | exp_data exp_cc exp_wr (all hex)
# wait=1 drains all results first, wait=0 issues straight behind the previous command
1 00 1 1 0 0 1 1234 1234 00 1
1 00 1 2 0 0 1 80F0 80F0 08 1
1 00 0 3 0 0 1 00FF 00FF 08 1
1 00 1 4 0 0 1 0000 0000 04 1
1 05 1 5 1 2 0 0000 0030 00 1
1 06 0 6 1 3 0 0000 00CB 08 1
1 07 1 7 1 2 0 0000 92F4 08 1
1 0A 1 5 5 0 0 0000 FFCF 09 1
1 09 0 6 0 0 0 0000 0000 04 1
1 13 1 6 3 0 0 0000 FFFF 08 1
1 08 1 0 1 2 0 0000 9144 0B 0
1 01 0 0 0 3 1 0078 0077 21 1
1 02 0 0 0 0 1 0080 00F8 08 1
1 03 1 1 0 1 1 8000 6DCC 02 1
1 04 0 2 0 0 1 0000 0008 01 1
1 04 0 3 0 4 1 0010 000F 00 1
1 0B 0 4 0 0 1 0080 0080 0B 1
1 0C 1 5 0 0 1 7FFF 8000 0B 1
1 0D 0 5 5 0 0 0000 00FF 09 1
1 15 1 6 0 0 1 FF00 0100 00 1
1 15 0 7 0 0 1 0080 0080 0A 1
1 0E 1 0 0 0 1 8001 4000 03 1
1 0F 0 1 0 0 1 0002 0081 0A 1
1 10 0 2 0 0 1 0081 00C0 0B 1
1 11 1 3 0 0 1 4001 8002 0A 1
1 12 0 4 0 0 1 0080 0000 07 1
1 12 1 4 0 0 1 0001 0003 00 1
1 14 1 5 0 2 1 00C8 9600 08 1
1 16 1 6 0 4 1 0064 0121 01 1
1 17 1 7 0 4 1 FF9C FFDF 09 1
1 16 1 1 0 4 1 0300 FFFF 0B 1
1 16 1 2 0 0 1 0010 FFFF 0B 1
1 00 0 3 0 0 1 00FD 00FD 09 1
1 17 1 0 0 3 1 0064 01DF 09 1
1 17 1 5 0 4 1 0200 FFFF 0B 1
1 16 1 1 0 4 1 0100 0155 01 1
0 00 1 2 0 0 1 0000 0000 05 1
0 01 1 3 1 4 0 0000 0158 00 1
1 08 0 0 3 2 0 0000 0058 00 0
1 16 1 4 0 4 1 0064 0121 01 1
0 16 1 5 0 3 1 0050 5000 04 1

// ==== jtkcpu_alu.sv ====
`timescale 1ns/1ps

module jtkcpu_alu import jtkcpu_exec_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cen,
    input  logic   alu_stb,
    input  issue_t iss,
    output logic   alu_req,
    output wb_t    alu_wb
);

logic [3:0]        msb;     // Sign bit position for the selected width
logic [DATA_W-1:0] x, y, r, rm;
logic [DATA_W:0]   sum;
logic [CC_W-1:0]   flags;
logic              cin;
wb_t               nxt;

always_comb begin
    msb   = iss.wide ? 4'd15 : 4'd7;
    x     = iss.wide ? iss.opnd0 : {8'h00, iss.opnd0[7:0]};
    y     = iss.wide ? iss.opnd1 : {8'h00, iss.opnd1[7:0]};
    cin   = iss.cc_in[CC_C];
    flags = iss.cc_in;
    sum   = '0;
    r     = x;
    case (iss.op)
        LD: begin
            flags[CC_V] = 1'b0;
        end
        ADD, ADC: begin
            sum = {1'b0, x} + {1'b0, y} + {16'd0, iss.op == ADC && cin};
            r   = sum[15:0];
            flags[CC_C] = iss.wide ? sum[16] : sum[8];
            flags[CC_V] = (x[msb] & y[msb] & ~r[msb]) | (~x[msb] & ~y[msb] & r[msb]);
            if (!iss.wide) begin
                flags[CC_H] = x[4] ^ y[4] ^ r[4];   // Carry out of bit 3
            end
        end
        SUB, SBC, CMP: begin
            sum = {1'b0, x} - {1'b0, y} - {16'd0, iss.op == SBC && cin};
            r   = sum[15:0];
            flags[CC_C] = iss.wide ? sum[16] : sum[8];  // Borrow
            flags[CC_V] = (x[msb] & ~y[msb] & ~r[msb]) | (~x[msb] & y[msb] & r[msb]);
        end
        AND: begin
            r = x & y;
            flags[CC_V] = 1'b0;
        end
        EOR: begin
            r = x ^ y;
            flags[CC_V] = 1'b0;
        end
        OR: begin
            r = x | y;
            flags[CC_V] = 1'b0;
        end
        CLR: begin
            r = '0;
            flags[CC_C] = 1'b0;
            flags[CC_V] = 1'b0;
        end
        COM: begin
            r = ~x;
            flags[CC_C] = 1'b1;
            flags[CC_V] = 1'b0;
        end
        NEG: begin
            r = ~x + 16'd1;
            flags[CC_C] = x != '0;
            flags[CC_V] = x[msb] & r[msb];  // Only the most negative value
        end
        INC: begin
            r = x + 16'd1;
            flags[CC_V] = ~x[msb] & r[msb];
        end
        DEC: begin
            r = x - 16'd1;
            flags[CC_V] = x[msb] & ~r[msb];
        end
        LSR: begin
            r = x >> 1;
            flags[CC_C] = x[0];
        end
        ROR: begin
            r = x >> 1;
            r[msb] = cin;   // Old carry enters at the top
            flags[CC_C] = x[0];
        end
        ASR: begin
            r = x >> 1;
            r[msb] = x[msb];
            flags[CC_C] = x[0];
        end
        ASL: begin
            r = x << 1;
            flags[CC_C] = x[msb];
            flags[CC_V] = x[msb] ^ r[msb];
        end
        ROL: begin
            r = {x[14:0], cin};
            flags[CC_C] = x[msb];
            flags[CC_V] = x[msb] ^ r[msb];
        end
        SEX: begin
            r = {{8{x[7]}}, x[7:0]};
            flags[CC_V] = 1'b0;
        end
        MUL: begin
            r = {8'h00, x[7:0]} * {8'h00, y[7:0]};
            flags[CC_C] = r[7];
        end
        ABS: begin
            if (x[msb]) begin
                r = ~x + 16'd1;
            end
            flags[CC_C] = 1'b0;
            flags[CC_V] = x[msb] & r[msb];
        end
        default: begin
            r = x;
        end
    endcase
    rm          = iss.wide ? r : {8'h00, r[7:0]};
    flags[CC_Z] = rm == '0;
    flags[CC_N] = r[msb];

    nxt.dst    = iss.dst;
    nxt.data   = rm;
    nxt.cc     = flags;
    nxt.wr_reg = iss.op != CMP;     // Compare only updates flags
    nxt.wide   = iss.wide;
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        alu_req <= 1'b0;
    end else if (cen) begin
        alu_req <= alu_stb;
    end
end

always_ff @(posedge clk) begin
    if (cen && alu_stb) begin
        alu_wb <= nxt;
    end
end

endmodule

// ==== jtkcpu_dispatch.sv ====
`timescale 1ns/1ps

module jtkcpu_dispatch import jtkcpu_exec_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic              cmd_stb,
    input  cmd_t              cmd,
    input  logic [DATA_W-1:0] dat_a,
    input  logic [DATA_W-1:0] dat_b,
    input  logic [CC_W-1:0]   cc,
    input  logic              div_busy,
    input  logic              slot_full,
    input  logic              wb_stb,
    output reg_idx_t          rd_a,
    output reg_idx_t          rd_b,
    output logic              stall,
    output issue_t            iss,
    output logic              alu_stb,
    output logic              div_stb
);

logic              accept;
logic              is_div, uses_a, uses_b, div_hit, carry_rd;
logic              div_tail;    // Divide result on its way into the register file
reg_idx_t          div_dst;
logic [PEND_W-1:0] pend;

assign rd_a   = cmd.src_a;
assign rd_b   = cmd.src_b;
assign accept = cen & cmd_stb & ~stall;

always_comb begin
    is_div   = cmd.op inside {DIVU, DIVS};
    uses_a   = !cmd.use_imm && cmd.op != CLR;
    uses_b   = cmd.op inside {ADD, ADC, SUB, SBC, AND, EOR, OR, CMP, MUL, DIVU, DIVS};
    carry_rd = cmd.op inside {ADC, SBC, ROR, ROL};
    div_hit  = (uses_a && cmd.src_a == div_dst) ||
               (uses_b && cmd.src_b == div_dst) ||
               cmd.dst == div_dst;
    // Scoreboard
    stall    = ((div_busy || div_tail) && (div_hit || is_div)) ||
               slot_full ||
               (carry_rd && pend != '0);
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        alu_stb  <= 1'b0;
        div_stb  <= 1'b0;
        div_tail <= 1'b0;
        pend     <= '0;
    end else begin
        div_tail <= div_busy;   // Covers the cycle the register write lands
        if (cen) begin
            alu_stb <= accept & ~is_div;
            div_stb <= accept & is_div;
        end
        case ({accept, wb_stb})
            2'b10:   pend <= pend + 1'b1;
            2'b01:   pend <= pend - 1'b1;
            default: pend <= pend;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        iss.op    <= cmd.op;
        iss.wide  <= cmd.wide;
        iss.dst   <= cmd.dst;
        iss.opnd0 <= cmd.use_imm ? cmd.imm : dat_a;
        iss.opnd1 <= dat_b;
        iss.cc_in <= cc;
        if (is_div) begin
            div_dst <= cmd.dst;
        end
    end
end

endmodule

// ==== jtkcpu_div.sv ====
`timescale 1ns/1ps

module jtkcpu_div import jtkcpu_exec_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cen,
    input  logic   div_stb,
    input  issue_t iss,
    output logic   div_busy,
    output logic   div_req,
    output wb_t    div_wb
);

logic                 running;
logic [DIV_CNT_W-1:0] cnt;
logic                 sgn_q, sgn_r, bad, signed_op;
logic [7:0]           dsr, rem, quo;
reg_idx_t             dst;
logic [CC_W-1:0]      cc_keep;
logic [15:0]          mag_a;
logic [7:0]           mag_b;
logic [8:0]           trial, diff;
logic                 ge;
logic [7:0]           rem_n, quo_n, q_s, r_s;
logic                 ovf;
wb_t                  fin;

assign div_busy = div_stb | running | div_req;

always_comb begin
    // Operand magnitudes for the signed form
    mag_a = (iss.op == DIVS && iss.opnd0[15]) ? ~iss.opnd0 + 16'd1 : iss.opnd0;
    mag_b = (iss.op == DIVS && iss.opnd1[7]) ? ~iss.opnd1[7:0] + 8'd1 : iss.opnd1[7:0];
    // Restoring step
    trial = {rem, quo[7]};
    diff  = trial - {1'b0, dsr};
    ge    = trial >= {1'b0, dsr};
    rem_n = ge ? diff[7:0] : trial[7:0];
    quo_n = {quo[6:0], ge};
    // Sign fix-up on the final step
    q_s   = sgn_q ? ~quo_n + 8'd1 : quo_n;
    r_s   = sgn_r ? ~rem_n + 8'd1 : rem_n;
    ovf   = bad || (signed_op && quo_n > (sgn_q ? 8'd128 : 8'd127));

    fin.dst    = dst;
    fin.data   = ovf ? 16'hFFFF : {r_s, q_s};   // Remainder high, quotient low
    fin.cc     = cc_keep;
    fin.cc[CC_C] = fin.data[0];
    fin.cc[CC_V] = ovf;
    fin.cc[CC_Z] = fin.data[7:0] == 8'h00;
    fin.cc[CC_N] = fin.data[7];
    fin.wr_reg = 1'b1;
    fin.wide   = 1'b1;
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        running <= 1'b0;
        cnt     <= '0;
        div_req <= 1'b0;
    end else if (cen) begin
        div_req <= running && cnt == DIV_LAST;
        if (div_stb) begin
            running <= 1'b1;
            cnt     <= '0;
        end else if (running) begin
            cnt <= cnt + 1'b1;
            if (cnt == DIV_LAST) begin
                running <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (cen) begin
        if (div_stb) begin
            rem       <= mag_a[15:8];
            quo       <= mag_a[7:0];    // Dividend low byte shifts out as quotient shifts in
            dsr       <= mag_b;
            bad       <= mag_b == 8'h00 || mag_a[15:8] >= mag_b;
            signed_op <= iss.op == DIVS;
            sgn_q     <= iss.op == DIVS && (iss.opnd0[15] ^ iss.opnd1[7]);
            sgn_r     <= iss.op == DIVS && iss.opnd0[15];
            dst       <= iss.dst;
            cc_keep   <= iss.cc_in;
        end else if (running) begin
            rem <= rem_n;
            quo <= quo_n;
        end
        if (running && cnt == DIV_LAST) begin
            div_wb <= fin;
        end
    end
end

endmodule

// ==== jtkcpu_exec.f ====
jtkcpu_exec_pkg.sv
jtkcpu_regs.sv
jtkcpu_dispatch.sv
jtkcpu_alu.sv
jtkcpu_div.sv
jtkcpu_wb_arb.sv
jtkcpu_exec.sv
tb_jtkcpu_exec.sv

// ==== jtkcpu_exec.sv ====
`timescale 1ns/1ps

module jtkcpu_exec import jtkcpu_exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cen,
    input  logic            cmd_stb,
    input  cmd_t            cmd,
    output logic            stall,
    output logic            wb_stb,
    output wb_t             wb,
    output logic [CC_W-1:0] cc
);

reg_idx_t          rd_a, rd_b;
logic [DATA_W-1:0] dat_a, dat_b;
issue_t            iss;
logic              alu_stb, div_stb;
logic              alu_req, div_req;
logic              div_busy, slot_full;
wb_t               alu_wb, div_wb;

jtkcpu_dispatch u_dispatch(
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .cen       ( cen       ),
    .cmd_stb   ( cmd_stb   ),
    .cmd       ( cmd       ),
    .dat_a     ( dat_a     ),
    .dat_b     ( dat_b     ),
    .cc        ( cc        ),
    .div_busy  ( div_busy  ),
    .slot_full ( slot_full ),
    .wb_stb    ( wb_stb    ),
    .rd_a      ( rd_a      ),
    .rd_b      ( rd_b      ),
    .stall     ( stall     ),
    .iss       ( iss       ),
    .alu_stb   ( alu_stb   ),
    .div_stb   ( div_stb   )
);

jtkcpu_alu u_alu(
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen     ( cen     ),
    .alu_stb ( alu_stb ),
    .iss     ( iss     ),
    .alu_req ( alu_req ),
    .alu_wb  ( alu_wb  )
);

jtkcpu_div u_div(
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .cen      ( cen      ),
    .div_stb  ( div_stb  ),
    .iss      ( iss      ),
    .div_busy ( div_busy ),
    .div_req  ( div_req  ),
    .div_wb   ( div_wb   )
);

jtkcpu_wb_arb u_arb(
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .cen       ( cen       ),
    .alu_req   ( alu_req   ),
    .alu_wb    ( alu_wb    ),
    .div_req   ( div_req   ),
    .div_wb    ( div_wb    ),
    .slot_full ( slot_full ),
    .wb_stb    ( wb_stb    ),
    .wb        ( wb        )
);

jtkcpu_regs u_regs(
    .clk    ( clk    ),
    .rst_n  ( rst_n  ),
    .rd_a   ( rd_a   ),
    .rd_b   ( rd_b   ),
    .wr_stb ( wb_stb ),
    .wr     ( wb     ),
    .dat_a  ( dat_a  ),
    .dat_b  ( dat_b  ),
    .cc     ( cc     )
);

endmodule

// ==== jtkcpu_exec_pkg.sv ====
package jtkcpu_exec_pkg;

localparam int DATA_W    = 16;
localparam int CC_W      = 8;
localparam int REG_N     = 8;
localparam int IDX_W     = $clog2(REG_N);
localparam int PEND_W    = 3;     // Write-backs in flight, worst case well below 8
localparam int DIV_STEPS = 8;     // One quotient bit per step
localparam int DIV_CNT_W = $clog2(DIV_STEPS);
localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS - 1);

// Condition-code bit positions
localparam int CC_C = 0;
localparam int CC_V = 1;
localparam int CC_Z = 2;
localparam int CC_N = 3;
localparam int CC_H = 5;

typedef logic [IDX_W-1:0] reg_idx_t;

typedef enum logic [7:0] {
    LD   = 8'h00,
    ADD  = 8'h01,
    ADC  = 8'h02,
    SUB  = 8'h03,
    SBC  = 8'h04,
    AND  = 8'h05,
    EOR  = 8'h06,
    OR   = 8'h07,
    CMP  = 8'h08,
    CLR  = 8'h09,
    COM  = 8'h0A,
    NEG  = 8'h0B,
    INC  = 8'h0C,
    DEC  = 8'h0D,
    LSR  = 8'h0E,
    ROR  = 8'h0F,
    ASR  = 8'h10,
    ASL  = 8'h11,
    ROL  = 8'h12,
    SEX  = 8'h13,
    MUL  = 8'h14,
    ABS  = 8'h15,
    DIVU = 8'h16,
    DIVS = 8'h17
} op_e;

typedef struct packed {
    op_e                op;
    logic               wide;       // 16-bit form
    reg_idx_t           dst;
    reg_idx_t           src_a;
    reg_idx_t           src_b;
    logic               use_imm;    // Immediate replaces src_a
    logic [DATA_W-1:0]  imm;
} cmd_t;

typedef struct packed {
    op_e                op;
    logic               wide;
    reg_idx_t           dst;
    logic [DATA_W-1:0]  opnd0;
    logic [DATA_W-1:0]  opnd1;
    logic [CC_W-1:0]    cc_in;
} issue_t;

typedef struct packed {
    reg_idx_t           dst;
    logic [DATA_W-1:0]  data;
    logic [CC_W-1:0]    cc;
    logic               wr_reg;     // Low for flag-only results
    logic               wide;       // Low writes the low byte only
} wb_t;

endpackage

// ==== jtkcpu_regs.sv ====
`timescale 1ns/1ps

module jtkcpu_regs import jtkcpu_exec_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  reg_idx_t          rd_a,
    input  reg_idx_t          rd_b,
    input  logic              wr_stb,
    input  wb_t               wr,
    output logic [DATA_W-1:0] dat_a,
    output logic [DATA_W-1:0] dat_b,
    output logic [CC_W-1:0]   cc
);

logic [DATA_W-1:0] rf [REG_N];

assign dat_a = rf[rd_a];    // Asynchronous read ports
assign dat_b = rf[rd_b];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < REG_N; i++) begin
            rf[i] <= '0;
        end
        cc <= '0;
    end else if (wr_stb) begin
        if (wr.wr_reg) begin
            if (wr.wide) begin
                rf[wr.dst] <= wr.data;
            end else begin
                rf[wr.dst][7:0] <= wr.data[7:0];   // High byte untouched
            end
        end
        cc <= wr.cc;    // Flags always follow the write-back
    end
end

endmodule

// ==== jtkcpu_wb_arb.sv ====
`timescale 1ns/1ps

module jtkcpu_wb_arb import jtkcpu_exec_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    input  logic alu_req,
    input  wb_t  alu_wb,
    input  logic div_req,
    input  wb_t  div_wb,
    output logic slot_full,
    output logic wb_stb,
    output wb_t  wb
);

wb_t  slot;
wb_t  grant;
logic any, park;

always_comb begin
    any  = div_req | slot_full | alu_req;
    park = alu_req & (div_req | slot_full);    // ALU entry must wait its turn
    if (div_req) begin
        grant = div_wb;
    end else if (slot_full) begin
        grant = slot;
    end else begin
        grant = alu_wb;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        slot_full <= 1'b0;
        wb_stb    <= 1'b0;
    end else begin
        wb_stb <= cen & any;    // Single clock pulse
        if (cen) begin
            if (park) begin
                slot_full <= 1'b1;
            end else if (!div_req) begin
                slot_full <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (cen) begin
        if (any) begin
            wb <= grant;
        end
        if (park) begin
            slot <= alu_wb;
        end
    end
end

endmodule

// ==== tb_jtkcpu_exec.sv ====
`timescale 1ns/1ps

module tb_jtkcpu_exec import jtkcpu_exec_pkg::*; ();

localparam int MAX_CASES    = 64;
localparam int DRAIN_CYCLES = 100;        // Longest wait for the last results

logic            clk = 1'b0;
logic            rst_n;
logic            cen;
logic            cmd_stb;
cmd_t            cmd;
logic            stall;
logic            wb_stb;
wb_t             wb;
logic [CC_W-1:0] cc;

cmd_t            case_cmd  [MAX_CASES];
wb_t             case_exp  [MAX_CASES];
logic            case_wait [MAX_CASES];   // Drain all results before issue
int              n_cases;
int              limit = 100;
int              cycles = 0;
int              issued = 0;

wb_t             alu_q [$];
wb_t             div_q [$];
int              alu_n [$];               // Issue numbers, same order as the queues
int              div_n [$];
logic            cc_due = 1'b0;
logic [CC_W-1:0] cc_exp;

jtkcpu_exec dut(
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen     ( cen     ),
    .cmd_stb ( cmd_stb ),
    .cmd     ( cmd     ),
    .stall   ( stall   ),
    .wb_stb  ( wb_stb  ),
    .wb      ( wb      ),
    .cc      ( cc      )
);

always #2 clk = ~clk;

always @(posedge clk) begin
    cen    <= ($urandom % 4) != 0;    // High three cycles in four
    cycles <= cycles + 1;
    if (cycles > limit) begin
        $display("Run exceeded %0d cycles without finishing", limit);
        $display("TEST FAILED");
        $fatal(1);
    end
end

function automatic bit same_wb(wb_t a, wb_t b);
    return a.dst == b.dst && a.data == b.data && a.wr_reg == b.wr_reg &&
           a.wide == b.wide;
endfunction

task automatic check_wb(input wb_t got, input wb_t exp);
    if (!same_wb(got, exp)) begin
        $display("FAILED %0t: wb r%0d %h wr %b wide %b, expected r%0d %h wr %b wide %b",
                 $time, got.dst, got.data, got.wr_reg, got.wide,
                 exp.dst, exp.data, exp.wr_reg, exp.wide);
        $display("TEST FAILED");
        $fatal(1);
    end
endtask

task automatic check_cc(input logic [CC_W-1:0] got, input logic [CC_W-1:0] exp);
    if (got !== exp) begin
        $display("FAILED %0t: cc %h, expected %h", $time, got, exp);
        $display("TEST FAILED");
        $fatal(1);
    end
endtask

// Write-back monitor, cc is checked on the cycle after the write lands
always @(negedge clk) begin : monitor
    logic use_div;
    wb_t  exp;
    if (rst_n) begin
        if (cc_due) begin
            check_cc(cc, cc_exp);
            cc_due = 1'b0;
        end
        if (wb_stb) begin
            if (alu_q.size() == 0 && div_q.size() == 0) begin
                $display("Write-back to r%0d with no command outstanding at %0t", wb.dst, $time);
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                if (alu_q.size() == 0) begin
                    use_div = 1'b1;
                end else if (div_q.size() == 0) begin
                    use_div = 1'b0;
                end else if (same_wb(wb, alu_q[0]) && same_wb(wb, div_q[0])) begin
                    use_div = div_n[0] < alu_n[0];
                end else if (same_wb(wb, div_q[0])) begin
                    use_div = 1'b1;
                end else if (same_wb(wb, alu_q[0])) begin
                    use_div = 1'b0;
                end else begin
                    use_div = div_n[0] < alu_n[0];
                end
                if (use_div) begin
                    exp = div_q.pop_front();
                    void'(div_n.pop_front());
                end else begin
                    exp = alu_q.pop_front();
                    void'(alu_n.pop_front());
                end
                check_wb(wb, exp);
                cc_exp = exp.cc;
                cc_due = 1'b1;
            end
        end
    end
end

task automatic read_cases();
    int          fd, code, n;
    string       line;
    logic [15:0] w, op, wide, dst, sa, sb, ui, imm, data, ccv, wr;
    fd = $fopen("exec_cases.txt", "r");
    n_cases = 0;
    if (fd == 0) begin
        $display("Cannot open exec_cases.txt");
        $display("TEST FAILED");
        $fatal(1);
    end else begin
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 3 || line[0] == 8'h23) begin
                continue;   // End of file, blank or comment line
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        w, op, wide, dst, sa, sb, ui, imm, data, ccv, wr);
            if (n == 11) begin
                case_wait[n_cases]        = w[0];
                case_cmd[n_cases].op      = op_e'(op[7:0]);
                case_cmd[n_cases].wide    = wide[0];
                case_cmd[n_cases].dst     = reg_idx_t'(dst);
                case_cmd[n_cases].src_a   = reg_idx_t'(sa);
                case_cmd[n_cases].src_b   = reg_idx_t'(sb);
                case_cmd[n_cases].use_imm = ui[0];
                case_cmd[n_cases].imm     = imm;
                case_exp[n_cases].dst     = reg_idx_t'(dst);
                case_exp[n_cases].data    = data;
                case_exp[n_cases].cc      = ccv[7:0];
                case_exp[n_cases].wr_reg  = wr[0];
                case_exp[n_cases].wide    = wide[0];
                n_cases++;
            end
        end
        $fclose(fd);
    end
endtask

task automatic issue_cmd(input int i);
    logic taken;
    if (case_wait[i]) begin
        while (alu_q.size() != 0 || div_q.size() != 0 || cc_due) begin
            @(negedge clk);
        end
    end
    repeat ($urandom % 3) @(posedge clk);   // Idle gap
    @(posedge clk);
    cmd <= case_cmd[i];
    taken = 1'b0;
    while (!taken) begin
        @(negedge clk);
        if (!stall) begin
            @(posedge clk);
            cmd_stb <= 1'b1;
            @(negedge clk);
            if (!stall && cen) begin
                taken = 1'b1;       // Accepted on the coming edge
                if (case_cmd[i].op inside {DIVU, DIVS}) begin
                    div_q.push_back(case_exp[i]);
                    div_n.push_back(issued);
                end else begin
                    alu_q.push_back(case_exp[i]);
                    alu_n.push_back(issued);
                end
                issued++;
            end
            @(posedge clk);
            cmd_stb <= 1'b0;
        end
    end
endtask

initial begin
    int drain;
    void'($urandom(50));
    rst_n   = 1'b0;
    cen     = 1'b0;
    cmd_stb = 1'b0;
    cmd     = '0;
    read_cases();
    limit = 40 * n_cases + 100;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_cases; i++) begin
        issue_cmd(i);
    end
    drain = 0;
    while ((alu_q.size() != 0 || div_q.size() != 0 || cc_due) && drain < DRAIN_CYCLES) begin
        @(negedge clk);
        drain++;
    end
    repeat (30) @(posedge clk);    // Catch any late duplicate
    if (alu_q.size() != 0 || div_q.size() != 0) begin
        $display("Results outstanding at end of run");
        $display("TEST FAILED");
        $fatal(1);
    end else begin
        $display("TEST OK");
        $finish;
    end
end

endmodule
